// File: decode_pkg.sv
package decode_pkg;

    //////////////////////////////////////////////////////////////////////
    // opcodes and function fields
    //////////////////////////////////////////////////////////////////////

    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;
    localparam logic [6:0] OP_BRANCH = 7'b1100011;
    localparam logic [6:0] OP_LOAD   = 7'b0000011;
    localparam logic [6:0] OP_STORE  = 7'b0100011;
    localparam logic [6:0] OP_IMM    = 7'b0010011;
    localparam logic [6:0] OP_ALU    = 7'b0110011;
    localparam logic [6:0] OP_MULDIV = 7'b0110011; // shares OP_ALU, split on funct7
    localparam logic [6:0] MULDIV_F7 = 7'b0000001;

    localparam logic [2:0] FUNC_LB  = 3'b000;
    localparam logic [2:0] FUNC_LH  = 3'b001;
    localparam logic [2:0] FUNC_LW  = 3'b010;
    localparam logic [2:0] FUNC_LBU = 3'b100;
    localparam logic [2:0] FUNC_LHU = 3'b101;
    localparam logic [2:0] FUNC_LWU = 3'b110;
    localparam logic [2:0] FUNC_SB  = 3'b000;
    localparam logic [2:0] FUNC_SH  = 3'b001;
    localparam logic [2:0] FUNC_SW  = 3'b010;

    localparam logic [2:0] FUNC_MUL    = 3'b000;
    localparam logic [2:0] FUNC_MULH   = 3'b001;
    localparam logic [2:0] FUNC_MULHSU = 3'b010;
    localparam logic [2:0] FUNC_MULHU  = 3'b011;
    localparam logic [2:0] FUNC_DIV    = 3'b100;
    localparam logic [2:0] FUNC_DIVU   = 3'b101;
    localparam logic [2:0] FUNC_REM    = 3'b110;
    localparam logic [2:0] FUNC_REMU   = 3'b111;

    localparam logic [1:0] LSU_LOAD  = 2'b01; // low bits of lsu code
    localparam logic [1:0] LSU_STORE = 2'b10;

    //////////////////////////////////////////////////////////////////////
    // types
    //////////////////////////////////////////////////////////////////////

    typedef enum logic [1:0] {
        SEL_REG  = 2'b00,
        SEL_PC   = 2'b01,
        SEL_IMM  = 2'b10,
        SEL_NONE = 2'b11  // operand unused
    } sel_t;

    typedef logic [4:0] lsu_op_t; // {size/sign, ld/st}
    typedef logic [4:0] reg_id_t;

    typedef struct packed {
        logic [6:0] funct7;
        reg_id_t    rs2;
        reg_id_t    rs1;
        logic [2:0] funct3;
        reg_id_t    rd;
        logic [6:0] opcode;
    } inst_r_t;

    typedef struct packed {
        logic [11:0] imm12;
        reg_id_t     rs1;
        logic [2:0]  funct3;
        reg_id_t     rd;
        logic [6:0]  opcode;
    } inst_i_t;

    typedef struct packed {
        logic [6:0] imm_hi;
        reg_id_t    rs2;
        reg_id_t    rs1;
        logic [2:0] funct3;
        logic [4:0] imm_lo;
        logic [6:0] opcode;
    } inst_s_t;

    typedef struct packed {
        logic [19:0] imm20;
        reg_id_t     rd;
        logic [6:0]  opcode;
    } inst_uf_t;

    typedef union packed {
        inst_r_t  r;
        inst_i_t  i;
        inst_s_t  s; // b format reads through s as well
        inst_uf_t u; // j format reads through u as well
    } inst_u;

    typedef struct packed {
        logic [6:0] alu_op1; // opcode
        logic [6:0] alu_op2; // funct7
        logic [2:0] alu_fn;  // funct3
        sel_t       sel_a;
        sel_t       sel_b;
    } alu_ctrl_t;

    typedef struct packed {
        lsu_op_t lsu_op;
        logic    wb_op;
        logic    jal;
        logic    jalr;
        logic    branchchk;
        reg_id_t rd_id;
        logic    store_sel_pc; // store data is next pc
        logic    is_load;
    } pipe_ctrl_t;

    typedef struct packed {
        logic [1:0] mul_op;
        logic [1:0] div_op;
        logic       mul_kill;
        logic       div_kill;
    } md_ctrl_t;

    typedef struct packed {
        logic rs1_mem;
        logic rs1_wb;
        logic rs2_mem;
        logic rs2_wb;
    } fwd_t;

    localparam alu_ctrl_t ALU_CTRL_BUBBLE = '{alu_op1: 7'd0, alu_op2: 7'd0, alu_fn: 3'd0,
                                              sel_a: SEL_NONE, sel_b: SEL_NONE};
    localparam pipe_ctrl_t PIPE_CTRL_BUBBLE = '0;
    localparam md_ctrl_t MD_CTRL_BUBBLE = '{mul_op: 2'b11, div_op: 2'b00,
                                            mul_kill: 1'b1, div_kill: 1'b1};

endpackage

// File: inst_field_decode.sv
module inst_field_decode import decode_pkg::*; (
    input  inst_u      instr_i,
    output alu_ctrl_t  alu_o,
    output pipe_ctrl_t pipe_o,
    output reg_id_t    rs1_o,
    output reg_id_t    rs2_o,
    output logic       rs1_rd_o,
    output logic       rs2_rd_o
);

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       is_lui, is_auipc, is_jal, is_jalr, is_branch;
    logic       is_load, is_store, is_imm, is_alu;

    assign opcode = instr_i.r.opcode;
    assign funct3 = instr_i.r.funct3;

    assign is_lui    = (opcode == OP_LUI);
    assign is_auipc  = (opcode == OP_AUIPC);
    assign is_jal    = (opcode == OP_JAL);
    assign is_jalr   = (opcode == OP_JALR);
    assign is_branch = (opcode == OP_BRANCH);
    assign is_load   = (opcode == OP_LOAD);
    assign is_store  = (opcode == OP_STORE);
    assign is_imm    = (opcode == OP_IMM);
    assign is_alu    = (opcode == OP_ALU);    // includes muldiv

    assign rs1_rd_o = is_jalr | is_branch | is_load | is_store | is_imm | is_alu;
    assign rs2_rd_o = is_branch | is_store | is_alu;

    // register ids, zeroed where the format has none
    assign rs1_o = (is_lui | is_auipc | is_jal) ? '0 : instr_i.r.rs1;
    assign rs2_o = rs2_rd_o ? instr_i.r.rs2 : '0;

    always_comb begin
        alu_o.alu_op1 = opcode;
        alu_o.alu_op2 = instr_i.r.funct7;      // shift type lives here too
        alu_o.alu_fn  = funct3;
        alu_o.sel_a   = SEL_REG;                // default, op and lui
        alu_o.sel_b   = SEL_REG;
        if (is_auipc | is_jal | is_branch) begin
            alu_o.sel_a = SEL_IMM;              // imm + pc for targets
            alu_o.sel_b = SEL_PC;
        end else if (is_jalr | is_load | is_store | is_imm) begin
            alu_o.sel_b = SEL_IMM;              // rs1 + imm
        end
    end

    always_comb begin
        pipe_o.lsu_op = '0;
        if (is_load) begin
            case (funct3)
                FUNC_LB, FUNC_LH, FUNC_LW,
                FUNC_LBU, FUNC_LHU, FUNC_LWU: pipe_o.lsu_op = {funct3, LSU_LOAD};
                default:                      pipe_o.lsu_op = '0;
            endcase
        end else if (is_store) begin
            case (funct3)
                FUNC_SB, FUNC_SH, FUNC_SW: pipe_o.lsu_op = {funct3, LSU_STORE};
                default:                   pipe_o.lsu_op = '0;
            endcase
        end
        pipe_o.wb_op        = is_lui | is_auipc | is_jal | is_jalr | is_load | is_imm | is_alu;
        pipe_o.jal          = is_jal;
        pipe_o.jalr         = is_jalr;
        pipe_o.branchchk    = is_branch;
        pipe_o.rd_id        = (is_branch | is_store) ? '0 : instr_i.r.rd; // no dest
        pipe_o.store_sel_pc = is_jal | is_jalr;                          // link value
        pipe_o.is_load      = (pipe_o.lsu_op[1:0] == LSU_LOAD);          // legal loads only
    end

endmodule

// File: imm_gen.sv
module imm_gen import decode_pkg::*; #(
    parameter int XLEN = 32
) (
    input  inst_u             instr_i,
    output logic [XLEN-1:0]   imm_o
);

    logic signed [11:0] imm_i;
    logic signed [11:0] imm_s;
    logic signed [12:0] imm_b;
    logic signed [31:0] imm_u;
    logic signed [20:0] imm_j;

    assign imm_i = instr_i.i.imm12;
    assign imm_s = {instr_i.s.imm_hi, instr_i.s.imm_lo};
    assign imm_b = {instr_i.s.imm_hi[6], instr_i.s.imm_lo[0],   // bit 12, bit 11
                    instr_i.s.imm_hi[5:0], instr_i.s.imm_lo[4:1], 1'b0};
    assign imm_u = {instr_i.u.imm20, 12'b0};
    assign imm_j = {instr_i.u.imm20[19], instr_i.u.imm20[7:0],  // bit 20, 19:12
                    instr_i.u.imm20[8], instr_i.u.imm20[18:9], 1'b0};

    // sign extension through signed size casts
    always_comb begin
        case (instr_i.r.opcode)
            OP_JALR,
            OP_LOAD,
            OP_IMM:    imm_o = XLEN'(imm_i);
            OP_STORE:  imm_o = XLEN'(imm_s);
            OP_BRANCH: imm_o = XLEN'(imm_b);
            OP_LUI,
            OP_AUIPC:  imm_o = XLEN'(imm_u);
            OP_JAL:    imm_o = XLEN'(imm_j);
            default:   imm_o = '0;                // r type, unknown
        endcase
    end

endmodule

// File: muldiv_decode.sv
module muldiv_decode import decode_pkg::*; (
    input  inst_u    instr_i,
    output md_ctrl_t md_o
);

    logic is_md;

    assign is_md = (instr_i.r.opcode == OP_MULDIV) && (instr_i.r.funct7 == MULDIV_F7);

    always_comb begin
        md_o = MD_CTRL_BUBBLE;                     // both units idle
        if (is_md) begin
            case (instr_i.r.funct3)
                FUNC_MUL:    md_o.mul_op = 2'b00;  // signed low
                FUNC_MULH:   md_o.mul_op = 2'b10;  // signed high
                FUNC_MULHSU: md_o.mul_op = 2'b01;  // signed x unsigned
                FUNC_MULHU:  md_o.mul_op = 2'b11;  // unsigned high
                FUNC_DIV:    md_o.div_op = 2'b11;  // signed quotient
                FUNC_DIVU:   md_o.div_op = 2'b10;  // unsigned quotient
                FUNC_REM:    md_o.div_op = 2'b01;  // signed remainder
                FUNC_REMU:   md_o.div_op = 2'b00;  // unsigned remainder
            endcase
            md_o.mul_kill = instr_i.r.funct3[2];   // mul group, bit 2 low
            md_o.div_kill = ~instr_i.r.funct3[2];
        end
    end

endmodule

// File: hazard_unit.sv
module hazard_unit import decode_pkg::*; (
    input  logic    clk,
    input  logic    rst,
    input  logic    flush_i,
    input  reg_id_t rs1_i,
    input  reg_id_t rs2_i,
    input  logic    rs1_rd_i,
    input  logic    rs2_rd_i,
    input  reg_id_t ex_rd_i,   // one ahead, at id/ex outputs
    input  logic    ex_wb_i,
    input  logic    ex_load_i,
    output fwd_t    fwd_o,
    output logic    stall_o,
    output logic    issue_o
);

    reg_id_t wb_rd_q;          // two ahead
    logic    wb_wb_q;
    logic    rs1_hit_ex, rs2_hit_ex;
    logic    rs1_hit_wb, rs2_hit_wb;
    logic    load_use;

    //////////////////////////////////////////////////////////////////////
    // issued history, second entry
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            wb_rd_q <= '0;
            wb_wb_q <= 1'b0;
        end else begin
            wb_rd_q <= ex_rd_i;    // bubbles shift in as zero
            wb_wb_q <= ex_wb_i;
        end
    end

    // x0 never matches
    assign rs1_hit_ex = rs1_rd_i && (rs1_i != '0) && (rs1_i == ex_rd_i);
    assign rs2_hit_ex = rs2_rd_i && (rs2_i != '0) && (rs2_i == ex_rd_i);
    assign rs1_hit_wb = rs1_rd_i && (rs1_i != '0) && (rs1_i == wb_rd_q);
    assign rs2_hit_wb = rs2_rd_i && (rs2_i != '0) && (rs2_i == wb_rd_q);

    assign fwd_o.rs1_mem = rs1_hit_ex && ex_wb_i;
    assign fwd_o.rs1_wb  = rs1_hit_wb && wb_wb_q;
    assign fwd_o.rs2_mem = rs2_hit_ex && ex_wb_i;
    assign fwd_o.rs2_wb  = rs2_hit_wb && wb_wb_q;

    //////////////////////////////////////////////////////////////////////
    // load-use stall and issue
    //////////////////////////////////////////////////////////////////////

    assign load_use = ex_load_i && (rs1_hit_ex || rs2_hit_ex); // data not ready yet
    assign stall_o  = load_use && !flush_i;                    // squashed, nothing to hold
    assign issue_o  = !(load_use || flush_i);

endmodule

// File: id_ex_reg.sv
module id_ex_reg import decode_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  logic            issue_i,
    input  alu_ctrl_t       alu_i,
    input  pipe_ctrl_t      pipe_i,
    input  md_ctrl_t        md_i,
    input  fwd_t            fwd_i,
    input  logic [XLEN-1:0] imm_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] opr1_i,
    input  logic [XLEN-1:0] opr2_i,
    input  logic [XLEN-1:0] next_pc_i,
    input  logic [5:0]      shamt_i,
    output alu_ctrl_t       alu_o,
    output pipe_ctrl_t      pipe_o,
    output md_ctrl_t        md_o,
    output fwd_t            fwd_o,
    output logic [XLEN-1:0] imm_o,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    output logic [XLEN-1:0] store_data_o,
    output logic [5:0]      shamt_o
);

    always_ff @(posedge clk) begin
        if (rst || !issue_i) begin               // bubble
            alu_o        <= ALU_CTRL_BUBBLE;
            pipe_o       <= PIPE_CTRL_BUBBLE;
            md_o         <= MD_CTRL_BUBBLE;
            fwd_o        <= '0;
            imm_o        <= '0;
            pc_o         <= '0;
            rs1_data_o   <= '0;
            rs2_data_o   <= '0;
            store_data_o <= '0;
            shamt_o      <= '0;
        end else begin
            alu_o        <= alu_i;
            pipe_o       <= pipe_i;
            md_o         <= md_i;
            fwd_o        <= fwd_i;
            imm_o        <= imm_i;
            pc_o         <= pc_i;
            rs1_data_o   <= opr1_i;
            rs2_data_o   <= opr2_i;
            store_data_o <= pipe_i.store_sel_pc ? next_pc_i : opr2_i; // link addr for jal/jalr
            shamt_o      <= shamt_i;
        end
    end

endmodule

// File: decode_stage.sv
module decode_stage import decode_pkg::*; #(
    parameter int XLEN = 32
) (
    input  logic            clk,
    input  logic            rst,
    input  inst_u           instr_i,
    input  logic [XLEN-1:0] pc_i,
    input  logic [XLEN-1:0] next_pc_i,
    input  logic [XLEN-1:0] opr1_i,      // regfile data for rs1_id_o
    input  logic [XLEN-1:0] opr2_i,
    input  logic            flush_i,     // branch taken or fetch nop
    output reg_id_t         rs1_id_o,
    output reg_id_t         rs2_id_o,
    output logic            stall_o,     // fetch holds instr
    output alu_ctrl_t       alu_o,
    output pipe_ctrl_t      pipe_o,
    output md_ctrl_t        md_o,
    output fwd_t            fwd_o,
    output logic [XLEN-1:0] imm_o,
    output logic [XLEN-1:0] pc_o,
    output logic [XLEN-1:0] rs1_data_o,
    output logic [XLEN-1:0] rs2_data_o,
    output logic [XLEN-1:0] store_data_o,
    output logic [5:0]      shamt_o
);

    alu_ctrl_t       alu_d;
    pipe_ctrl_t      pipe_d;
    md_ctrl_t        md_d;
    fwd_t            fwd_d;
    logic [XLEN-1:0] imm_d;
    logic            rs1_rd, rs2_rd;
    logic            issue;

    inst_field_decode i_inst_field_decode (
        .instr_i (instr_i), .alu_o (alu_d), .pipe_o (pipe_d),
        .rs1_o (rs1_id_o), .rs2_o (rs2_id_o), .rs1_rd_o (rs1_rd), .rs2_rd_o (rs2_rd)
    );

    imm_gen #(.XLEN(XLEN)) i_imm_gen (.instr_i (instr_i), .imm_o (imm_d));

    muldiv_decode i_muldiv_decode (.instr_i (instr_i), .md_o (md_d));

    hazard_unit i_hazard_unit (
        .clk (clk), .rst (rst), .flush_i (flush_i),
        .rs1_i (rs1_id_o), .rs2_i (rs2_id_o), .rs1_rd_i (rs1_rd), .rs2_rd_i (rs2_rd),
        .ex_rd_i (pipe_o.rd_id), .ex_wb_i (pipe_o.wb_op), .ex_load_i (pipe_o.is_load),
        .fwd_o (fwd_d), .stall_o (stall_o), .issue_o (issue)
    );

    id_ex_reg #(.XLEN(XLEN)) i_id_ex_reg (
        .clk (clk), .rst (rst), .issue_i (issue),
        .alu_i (alu_d), .pipe_i (pipe_d), .md_i (md_d), .fwd_i (fwd_d), .imm_i (imm_d),
        .pc_i (pc_i), .opr1_i (opr1_i), .opr2_i (opr2_i), .next_pc_i (next_pc_i),
        .shamt_i ({1'b0, instr_i.r.rs2}),                 // shamt sits in rs2 field
        .alu_o (alu_o), .pipe_o (pipe_o), .md_o (md_o), .fwd_o (fwd_o), .imm_o (imm_o),
        .pc_o (pc_o), .rs1_data_o (rs1_data_o), .rs2_data_o (rs2_data_o),
        .store_data_o (store_data_o), .shamt_o (shamt_o)
    );

endmodule

// File: tb_decode_stage.sv
module tb_decode_stage import decode_pkg::*; #(
    parameter int XLEN = 32
);

    logic            clk;
    logic            rst;
    inst_u           instr_i;
    logic [XLEN-1:0] pc_i;
    logic [XLEN-1:0] next_pc_i;
    logic [XLEN-1:0] opr1_i;
    logic [XLEN-1:0] opr2_i;
    logic            flush_i;
    reg_id_t         rs1_id_o;
    reg_id_t         rs2_id_o;
    logic            stall_o;
    alu_ctrl_t       alu_o;
    pipe_ctrl_t      pipe_o;
    md_ctrl_t        md_o;
    fwd_t            fwd_o;
    logic [XLEN-1:0] imm_o;
    logic [XLEN-1:0] pc_o;
    logic [XLEN-1:0] rs1_data_o;
    logic [XLEN-1:0] rs2_data_o;
    logic [XLEN-1:0] store_data_o;
    logic [5:0]      shamt_o;

    decode_stage #(.XLEN(XLEN)) i_decode_stage (
        .clk (clk), .rst (rst), .instr_i (instr_i), .pc_i (pc_i), .next_pc_i (next_pc_i),
        .opr1_i (opr1_i), .opr2_i (opr2_i), .flush_i (flush_i),
        .rs1_id_o (rs1_id_o), .rs2_id_o (rs2_id_o), .stall_o (stall_o),
        .alu_o (alu_o), .pipe_o (pipe_o), .md_o (md_o), .fwd_o (fwd_o), .imm_o (imm_o),
        .pc_o (pc_o), .rs1_data_o (rs1_data_o), .rs2_data_o (rs2_data_o),
        .store_data_o (store_data_o), .shamt_o (shamt_o)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;        // period 100
    end

    //////////////////////////////////////////////////////////////////////
    // failure reporting and typed compares
    //////////////////////////////////////////////////////////////////////

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_alu(input string name, input alu_ctrl_t got, input alu_ctrl_t exp);
        if (got !== exp)
            report_failure($sformatf("error: time %0t %s expected %h got %h",
                                     $time, name, exp, got));
    endtask

    task automatic check_pipe(input string name, input pipe_ctrl_t got, input pipe_ctrl_t exp);
        if (got !== exp)
            report_failure($sformatf("error: time %0t %s expected %h got %h",
                                     $time, name, exp, got));
    endtask

    task automatic check_md(input string name, input md_ctrl_t got, input md_ctrl_t exp);
        if (got !== exp)
            report_failure($sformatf("error: time %0t %s expected %h got %h",
                                     $time, name, exp, got));
    endtask

    task automatic check_fwd(input string name, input fwd_t got, input fwd_t exp);
        if (got !== exp)
            report_failure($sformatf("error: time %0t %s expected %b got %b",
                                     $time, name, exp, got));
    endtask

    task automatic check_word(input string name, input logic [XLEN-1:0] got,
                              input logic [XLEN-1:0] exp);
        if (got !== exp)
            report_failure($sformatf("error: time %0t %s expected %h got %h",
                                     $time, name, exp, got));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        if (got !== exp)
            report_failure($sformatf("error: time %0t %s expected %b got %b",
                                     $time, name, exp, got));
    endtask

    task automatic check_id(input string name, input reg_id_t got, input reg_id_t exp);
        if (got !== exp)
            report_failure($sformatf("error: time %0t %s expected %0d got %0d",
                                     $time, name, exp, got));
    endtask

    task automatic check_shamt(input string name, input logic [5:0] got,
                               input logic [5:0] exp);
        if (got !== exp)
            report_failure($sformatf("error: time %0t %s expected %h got %h",
                                     $time, name, exp, got));
    endtask

    // register file read ids by opcode
    function automatic reg_id_t rs1_expected(input logic [31:0] word);
        if (word[6:0] == OP_LUI || word[6:0] == OP_AUIPC || word[6:0] == OP_JAL)
            return '0;                             // no rs1 field
        return word[19:15];
    endfunction

    function automatic reg_id_t rs2_expected(input logic [31:0] word);
        if (word[6:0] == OP_BRANCH || word[6:0] == OP_STORE || word[6:0] == OP_ALU)
            return word[24:20];
        return '0;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // reset, then one vector line per clock
    //////////////////////////////////////////////////////////////////////

    initial begin
        int          fd;
        int          n;
        int          cycles;
        int          guard;
        int          line_no;
        string       line;
        logic [31:0] v [16];      // one parsed vector line

        rst       = 1'b1;
        instr_i   = '0;
        pc_i      = '0;
        next_pc_i = '0;
        opr1_i    = '0;
        opr2_i    = '0;
        flush_i   = 1'b0;

        fd = $fopen("decode_vectors.txt", "r");
        if (fd == 0)
            report_failure("could not open decode_vectors.txt");

        cycles = 0;
        guard  = 0;
        while (cycles < 10) begin                 // reset for 10 cycles
            @(posedge clk);
            cycles = cycles + 1;
            guard  = guard + 1;
            if (guard > 100)
                report_failure("timed out while holding reset");
        end
        #10;

        // everything registered should sit at bubble values
        check_alu("alu_o", alu_o, '{7'd0, 7'd0, 3'd0, SEL_NONE, SEL_NONE});
        check_pipe("pipe_o", pipe_o, '0);
        check_md("md_o", md_o, '{2'b11, 2'b00, 1'b1, 1'b1});
        check_fwd("fwd_o", fwd_o, '0);
        check_word("imm_o", imm_o, '0);
        check_word("pc_o", pc_o, '0);
        check_word("rs1_data_o", rs1_data_o, '0);
        check_word("rs2_data_o", rs2_data_o, '0);
        check_word("store_data_o", store_data_o, '0);
        check_shamt("shamt_o", shamt_o, '0);
        check_bit("stall_o", stall_o, 1'b0);
        rst = 1'b0;

        line_no = 0;
        guard   = 0;
        while (!$feof(fd)) begin
            guard = guard + 1;
            if (guard > 1000)
                report_failure("timed out reading the vector file, no end of file");
            n = $fgets(line, fd);
            if (n == 0 || line.len() < 8 || line[0] == "#")
                continue;                          // blank or comment line
            n = $sscanf(line, "%h %h %h %h %h %h %h %h %h %h %h %h %h %h %h %h",
                        v[0], v[1], v[2], v[3], v[4], v[5], v[6], v[7],
                        v[8], v[9], v[10], v[11], v[12], v[13], v[14], v[15]);
            if (n != 16)
                report_failure($sformatf("vector line %0d is malformed", line_no + 1));

            instr_i   = v[0];                      // at edge + 10
            pc_i      = v[1];
            next_pc_i = v[2];
            opr1_i    = v[3];
            opr2_i    = v[4];
            flush_i   = v[5][0];

            #40;
            check_bit("stall_o", stall_o, v[6][0]);   // same cycle, combinational
            check_id("rs1_id_o", rs1_id_o, rs1_expected(v[0]));
            check_id("rs2_id_o", rs2_id_o, rs2_expected(v[0]));

            @(posedge clk);
            #5;                                    // registered results settled
            check_alu("alu_o", alu_o, v[7][20:0]);
            check_pipe("pipe_o", pipe_o, v[8][15:0]);
            check_md("md_o", md_o, v[9][5:0]);
            check_fwd("fwd_o", fwd_o, v[10][3:0]);
            check_word("imm_o", imm_o, v[11]);
            check_word("pc_o", pc_o, v[12]);
            check_word("rs1_data_o", rs1_data_o, v[13]);
            check_word("rs2_data_o", rs2_data_o, v[14]);
            check_word("store_data_o", store_data_o, v[15]);
            // shift amount is instr bits 24:20, zero in a bubble
            check_shamt("shamt_o", shamt_o,
                        (v[5][0] || v[6][0]) ? 6'd0 : {1'b0, v[0][24:20]});
            #5;
            line_no = line_no + 1;
        end
        $fclose(fd);

        if (line_no > 0) begin
            $display("PASS: all tests");
            $finish;
        end else begin
            report_failure("no vector lines were read");
        end
    end

endmodule

// File: decode_vectors.txt
# instr pc next_pc opr1 opr2 flush | stall alu pipe md fwd imm pc rs1_data rs2_data store_data
# stall is checked in the same cycle, the rest after the next rising edge (all hex)
123450B7 00000100 00000104 A0000001 B0000001 0 0 0DC4D0 0404 33 0 12345000 00000100 A0000001 B0000001 B0000001
FFFFF117 00000104 00000108 A0000002 B0000002 0 0 05FFF9 0408 33 0 FFFFF000 00000104 A0000002 B0000002 B0000002
FFF08193 00000108 0000010C A0000003 B0000003 0 0 04FF82 040C 33 4 FFFFFFFF 00000108 A0000003 B0000003 B0000003
00018233 0000010C 00000110 A0000004 B0000004 0 0 0CC000 0410 33 8 00000000 0000010C A0000004 B0000004 B0000004
00412423 00000110 00000114 A0000005 B0000005 0 0 08C022 5000 33 2 00000008 00000110 A0000005 B0000005 B0000005
FE0208E3 00000114 00000118 A0000006 B0000006 0 0 18FF89 0080 33 4 FFFFFFF0 00000114 A0000006 B0000006 B0000006
0040A283 00000118 0000011C A0000007 B0000007 0 0 00C022 4C15 33 0 00000004 00000118 A0000007 B0000007 B0000007
00128333 0000011C 00000120 A0000008 B0000008 0 1 00000F 0000 33 0 00000000 00000000 00000000 00000000 00000000
00128333 0000011C 00000120 A0000009 B0000009 0 0 0CC000 0418 33 4 00000000 0000011C A0000009 B0000009 B0000009
02000033 00000124 00000128 A000000A B000000A 0 0 0CC080 0400 01 0 00000000 00000124 A000000A B000000A B000000A
02001033 00000128 0000012C A000000B B000000B 0 0 0CC090 0400 21 0 00000000 00000128 A000000B B000000B B000000B
02002033 0000012C 00000130 A000000C B000000C 0 0 0CC0A0 0400 11 0 00000000 0000012C A000000C B000000C B000000C
02003033 00000130 00000134 A000000D B000000D 0 0 0CC0B0 0400 31 0 00000000 00000130 A000000D B000000D B000000D
02004033 00000134 00000138 A000000E B000000E 0 0 0CC0C0 0400 3E 0 00000000 00000134 A000000E B000000E B000000E
02005033 00000138 0000013C A000000F B000000F 0 0 0CC0D0 0400 3A 0 00000000 00000138 A000000F B000000F B000000F
02006033 0000013C 00000140 A0000010 B0000010 0 0 0CC0E0 0400 36 0 00000000 0000013C A0000010 B0000010 B0000010
02007033 00000140 00000144 A0000011 B0000011 0 0 0CC0F0 0400 32 0 00000000 00000140 A0000011 B0000011 B0000011
00002483 00000144 00000148 A0000012 B0000012 0 0 00C022 4C25 33 0 00000000 00000144 A0000012 B0000012 B0000012
00048533 00000148 0000014C A0000013 B0000013 1 0 00000F 0000 33 0 00000000 00000000 00000000 00000000 00000000
00050613 0000014C 00000150 A0000014 B0000014 0 0 04C002 0430 33 0 00000000 0000014C A0000014 B0000014 B0000014
010000EF 00000150 00000154 A0000015 B0000015 0 0 1BC009 0606 33 0 00000010 00000150 A0000015 B0000015 00000154
00008067 00000154 00000158 A0000016 B0000016 0 0 19C002 0502 33 8 00000000 00000154 A0000016 B0000016 00000158

// File: vlog.f
decode_pkg.sv
inst_field_decode.sv
imm_gen.sv
muldiv_decode.sv
hazard_unit.sv
id_ex_reg.sv
decode_stage.sv
tb_decode_stage.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -f vlog.f --top-module tb_decode_stage -o sim_decode

if ! ./obj_dir/sim_decode > sim.log 2>&1; then
    cat sim.log
    exit 1
fi
cat sim.log

grep -q "PASS: all tests" sim.log || exit 1
